// ==== rtl/vsaPkg.sv ====
// shared types, sequencer step enum, opcode and function codes, pc increment
package vsaPkg;

    // word widths fixed by the 12-bit instruction format
    typedef logic [4:0]  dataWordT;  // register value, pc, data address
    typedef logic [11:0] instrT;     // one instruction word
    typedef logic [1:0]  regIdxT;    // register number, r0 reads zero
    typedef logic [2:0]  opcodeT;    // instr[11:9]
    typedef logic [2:0]  funcT;      // r-format instr[2:0]

    // the five steps of the non-pipelined unit
    typedef enum logic [2:0] {
        IF  = 3'd0,  // fetch
        ID  = 3'd1,  // decode, operand read
        EX  = 3'd2,  // alu result registered
        MEM = 3'd3,  // bus access, pc update
        WB  = 3'd4   // register write-back
    } stateE;

    // opcodes, 6 and 7 fall through as no-ops
    parameter opcodeT OP_LW   = 3'd0;
    parameter opcodeT OP_SW   = 3'd1;
    parameter opcodeT OP_BEQZ = 3'd2;
    parameter opcodeT OP_ALU  = 3'd3;  // r-format, func selects op
    parameter opcodeT OP_ADDI = 3'd4;
    parameter opcodeT OP_SUBI = 3'd5;

    // r-format function codes
    parameter funcT FN_ADD = 3'd0;
    parameter funcT FN_SUB = 3'd1;
    parameter funcT FN_AND = 3'd2;
    parameter funcT FN_OR  = 3'd3;
    parameter funcT FN_XOR = 3'd4;
    parameter funcT FN_NOT = 3'd5;  // ~A, B ignored
    parameter funcT FN_SRL = 3'd6;  // one bit right, zero fill
    parameter funcT FN_SRA = 3'd7;  // one bit right, sign fill

    // instructions are two address units apart
    parameter dataWordT PC_STEP = 5'd2;

endpackage

// ==== rtl/vsaMemIf.sv ====
// interface: data memory request between sequencer and wishbone master, modports
`timescale 1ns/1ps

interface vsaMemIf;
    import vsaPkg::*;

    logic     req;    // held through MEM for lw/sw
    logic     write;  // sw when high
    dataWordT addr;   // from ALUOutput
    dataWordT wdata;  // store data, operand B
    logic     done;   // one-cycle pulse after ack
    dataWordT rdata;  // valid while done is high

    // sequencer side
    modport master (
        output req,
        output write,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    // bus master side
    modport slave (
        input  req,
        input  write,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// ==== rtl/vsaAlu.sv ====
// module: combinational alu for address, arithmetic, logic, shift and branch target
`timescale 1ns/1ps

module vsaAlu (
    input  vsaPkg::instrT    ir,
    input  vsaPkg::dataWordT opA,
    input  vsaPkg::dataWordT opB,
    input  vsaPkg::dataWordT npc,
    output vsaPkg::dataWordT aluResult
);
    import vsaPkg::*;

    opcodeT   opcode;
    funcT     func;
    dataWordT imm;

    assign opcode = ir[11:9];
    assign func   = ir[2:0];
    assign imm    = ir[4:0];  // raw, no sign extension

    always_comb begin
        case (opcode)
            OP_LW, OP_SW: aluResult = opA + imm;  // effective address
            OP_ALU: begin
                case (func)
                    FN_ADD:  aluResult = opA + opB;
                    FN_SUB:  aluResult = opA - opB;
                    FN_AND:  aluResult = opA & opB;
                    FN_OR:   aluResult = opA | opB;
                    FN_XOR:  aluResult = opA ^ opB;
                    FN_NOT:  aluResult = ~opA;
                    FN_SRL:  aluResult = {1'b0, opA[4:1]};
                    default: aluResult = {opA[4], opA[4:1]};  // sra
                endcase
            end
            OP_ADDI: aluResult = opA + imm;
            OP_SUBI: aluResult = opA - imm;
            // target counts in instructions, so low four bits doubled
            OP_BEQZ: aluResult = npc + {imm[3:0], 1'b0};
            default: aluResult = npc;  // opcodes 6/7, result unused
        endcase
    end

endmodule

// ==== rtl/vsaRegFile.sv ====
// module: r1..r3 register file with hard-wired r0, two read ports, one write port
`timescale 1ns/1ps

module vsaRegFile (
    input  logic             clock,
    input  logic             rstN,
    input  vsaPkg::regIdxT   rdIdxA,
    input  vsaPkg::regIdxT   rdIdxB,
    input  logic             wrEn,
    input  vsaPkg::regIdxT   wrIdx,
    input  vsaPkg::dataWordT wrData,
    output vsaPkg::dataWordT rdA,
    output vsaPkg::dataWordT rdB
);
    import vsaPkg::*;

    dataWordT regs [1:3];  // no storage behind r0

    // r0 decodes to constant zero
    assign rdA = (rdIdxA == 2'd0) ? '0 : regs[rdIdxA];
    assign rdB = (rdIdxB == 2'd0) ? '0 : regs[rdIdxB];

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 1; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 4; i++) begin
                if (wrEn && wrIdx == regIdxT'(i))
                    regs[i] <= wrData;  // single port, one hit at most
            end
        end
    end

    // sequencer must suppress write-back aimed at r0
    assert property (@(posedge clock) disable iff (!rstN) wrEn |-> wrIdx != 2'd0);

endmodule

// ==== rtl/vsaDataPort.sv ====
// wishbone classic master running one data memory cycle per request
`timescale 1ns/1ps

module vsaDataPort (
    input  logic             clock,
    input  logic             rstN,
    input  vsaPkg::dataWordT wbDatI,
    input  logic             wbAck,
    output logic             wbCyc,
    output logic             wbStb,
    output logic             wbWe,
    output vsaPkg::dataWordT wbAdr,
    output vsaPkg::dataWordT wbDatO,
    vsaMemIf.slave           memIf
);
    import vsaPkg::*;

    typedef enum logic {IDLE, BUSY} portStateE;

    portStateE portState;

    // bus strobes and done pulse
    always_ff @(posedge clock) begin
        if (!rstN) begin
            portState  <= IDLE;
            wbCyc      <= 1'b0;
            wbStb      <= 1'b0;
            wbWe       <= 1'b0;
            memIf.done <= 1'b0;
        end else begin
            memIf.done <= 1'b0;  // pulse by default low
            case (portState)
                IDLE: begin
                    // req still high during done is no new access
                    if (memIf.req && !memIf.done) begin
                        portState <= BUSY;
                        wbCyc     <= 1'b1;
                        wbStb     <= 1'b1;
                        wbWe      <= memIf.write;
                    end
                end
                default: begin
                    if (wbAck) begin  // slave wait ends here
                        portState  <= IDLE;
                        wbCyc      <= 1'b0;
                        wbStb      <= 1'b0;
                        wbWe       <= 1'b0;
                        memIf.done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // address, store data and read data
    always_ff @(posedge clock) begin
        if (portState == IDLE && memIf.req && !memIf.done) begin
            wbAdr  <= memIf.addr;
            wbDatO <= memIf.wdata;
        end
        if (portState == BUSY && wbAck)
            memIf.rdata <= wbDatI;  // seen by sequencer with done
    end

    // sequencer keeps its request up for the whole bus cycle
    assert property (@(posedge clock) disable iff (!rstN) (portState == BUSY) |-> memIf.req);

    // master holds still across slave wait states
    assert property (@(posedge clock) disable iff (!rstN)
        (wbCyc && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && wbCyc));

endmodule

// ==== rtl/vsaSequencer.sv ====
// five-step control fsm with pc, npc, ir, operands, alu output, cond and lmd
`timescale 1ns/1ps

module vsaSequencer (
    input  logic             clock,
    input  logic             rstN,
    input  vsaPkg::instrT    instruction,
    input  vsaPkg::dataWordT aluResult,
    input  vsaPkg::dataWordT rdA,
    input  vsaPkg::dataWordT rdB,
    output vsaPkg::dataWordT pc,
    output logic             fetch,
    output vsaPkg::instrT    ir,
    output vsaPkg::dataWordT opA,
    output vsaPkg::dataWordT opB,
    output vsaPkg::dataWordT npc,
    output vsaPkg::regIdxT   rdIdxA,
    output vsaPkg::regIdxT   rdIdxB,
    output logic             wrEn,
    output vsaPkg::regIdxT   wrIdx,
    output vsaPkg::dataWordT wrData,
    output logic             takenCond,
    vsaMemIf.master          memIf
);
    import vsaPkg::*;

    stateE    state;
    dataWordT aluOut;  // ALUOutput
    logic     cond;    // A == 0, for beqz
    dataWordT lmd;     // load memory data

    // instruction fields
    opcodeT opcode;
    regIdxT src1;
    regIdxT src2;
    regIdxT dstR;  // r-format destination
    regIdxT dstI;  // i-format destination on the src2 bits

    logic isMem;     // lw or sw
    logic isLw;
    logic isBranch;
    logic isRegAlu;  // r-format
    logic isImmAlu;  // addi, subi
    logic writes;    // instruction has a register result

    assign opcode = ir[11:9];
    assign src1   = ir[8:7];
    assign src2   = ir[6:5];
    assign dstR   = ir[4:3];
    assign dstI   = ir[6:5];

    assign isLw     = opcode == OP_LW;
    assign isMem    = isLw || opcode == OP_SW;
    assign isBranch = opcode == OP_BEQZ;
    assign isRegAlu = opcode == OP_ALU;
    assign isImmAlu = opcode == OP_ADDI || opcode == OP_SUBI;
    assign writes   = isRegAlu || isImmAlu || isLw;

    assign fetch     = state == IF;
    assign rdIdxA    = src1;  // read in ID
    assign rdIdxB    = src2;
    assign takenCond = cond;

    // r0 target dropped at write-back select
    assign wrIdx  = isRegAlu ? dstR : dstI;
    assign wrData = isLw ? lmd : aluOut;
    assign wrEn   = state == WB && writes && wrIdx != 2'd0;

    // memory request only while sitting in MEM
    assign memIf.req   = state == MEM && isMem;
    assign memIf.write = opcode == OP_SW;
    assign memIf.addr  = aluOut;
    assign memIf.wdata = opB;

    // step and pc
    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= IF;
            pc    <= '0;
        end else begin
            case (state)
                IF: state <= ID;
                ID: state <= EX;
                EX: state <= MEM;
                MEM: begin
                    // lw/sw wait here for the bus cycle
                    if (!isMem || memIf.done) begin
                        state <= WB;
                        pc    <= (isBranch && cond) ? aluOut : npc;
                    end
                end
                default: state <= IF;  // WB
            endcase
        end
    end

    // datapath registers loaded per step
    always_ff @(posedge clock) begin
        case (state)
            IF: begin
                ir  <= instruction;
                npc <= pc + PC_STEP;
            end
            ID: begin
                opA <= rdA;
                opB <= rdB;
            end
            EX: begin
                aluOut <= aluResult;
                cond   <= opA == '0;
            end
            MEM: begin
                if (isLw && memIf.done)
                    lmd <= memIf.rdata;
            end
            default: ;
        endcase
    end

    // r0 as branch register is always taken
    assert property (@(posedge clock) disable iff (!rstN)
        (state == WB && isBranch && src1 == 2'd0) |-> pc == aluOut);

    // done only answers a request still held in MEM
    assert property (@(posedge clock) disable iff (!rstN) memIf.done |-> memIf.req);

endmodule

// ==== rtl/vsaTop.sv ====
// processor top with sequencer, alu, register file and wishbone data port
`timescale 1ns/1ps

module vsaTop (
    input  logic             clock,
    input  logic             rstN,
    input  vsaPkg::instrT    instruction,  // combinational fetch return
    input  vsaPkg::dataWordT wbDatI,
    input  logic             wbAck,
    output vsaPkg::dataWordT pc,
    output vsaPkg::dataWordT wbAdr,
    output vsaPkg::dataWordT wbDatO,
    output logic             fetch,
    output logic             wbCyc,
    output logic             wbStb,
    output logic             wbWe
);
    import vsaPkg::*;

    instrT    ir;
    dataWordT opA;
    dataWordT opB;
    dataWordT npc;
    dataWordT aluResult;
    regIdxT   rdIdxA;
    regIdxT   rdIdxB;
    dataWordT rdA;
    dataWordT rdB;
    logic     wrEn;
    regIdxT   wrIdx;
    dataWordT wrData;

    vsaMemIf memBus ();  // sequencer to data port

    vsaSequencer u_seq (
        .clock      (clock),
        .rstN       (rstN),
        .instruction(instruction),
        .aluResult  (aluResult),
        .rdA        (rdA),
        .rdB        (rdB),
        .pc         (pc),
        .fetch      (fetch),
        .ir         (ir),
        .opA        (opA),
        .opB        (opB),
        .npc        (npc),
        .rdIdxA     (rdIdxA),
        .rdIdxB     (rdIdxB),
        .wrEn       (wrEn),
        .wrIdx      (wrIdx),
        .wrData     (wrData),
        .takenCond  (),  // branch flag not needed at this level
        .memIf      (memBus)
    );

    vsaAlu u_alu (
        .ir       (ir),
        .opA      (opA),
        .opB      (opB),
        .npc      (npc),
        .aluResult(aluResult)
    );

    vsaRegFile u_regFile (
        .clock (clock),
        .rstN  (rstN),
        .rdIdxA(rdIdxA),
        .rdIdxB(rdIdxB),
        .wrEn  (wrEn),
        .wrIdx (wrIdx),
        .wrData(wrData),
        .rdA   (rdA),
        .rdB   (rdB)
    );

    vsaDataPort u_dataPort (
        .clock (clock),
        .rstN  (rstN),
        .wbDatI(wbDatI),
        .wbAck (wbAck),
        .wbCyc (wbCyc),
        .wbStb (wbStb),
        .wbWe  (wbWe),
        .wbAdr (wbAdr),
        .wbDatO(wbDatO),
        .memIf (memBus)
    );

endmodule

// ==== tests/vsaTb.sv ====
// testbench with clock, program rom, wishbone slave, reference model, compare tasks, watchdog
`timescale 1ns/1ps

module vsaTb;
    import vsaPkg::*;

    localparam int NumRuns     = 6;
    localparam int TotalInstr  = 16 + 10 + 10 + 11 + 24 + 7;  // sum of run lengths
    localparam int LimitCycles = (TotalInstr + NumRuns) * (5 + 4) + NumRuns * 11 + 200;
    localparam instrT Nop      = 12'hC00;  // opcode 6 only steps the pc

    logic     clock = 1'b0;
    logic     rstN = 1'b0;
    instrT    instruction = '0;
    dataWordT wbDatI = '0;
    logic     wbAck = 1'b0;
    dataWordT pc;
    dataWordT wbAdr;
    dataWordT wbDatO;
    logic     fetch;
    logic     wbCyc;
    logic     wbStb;
    logic     wbWe;

    instrT    rom [32];      // indexed by pc
    dataWordT dataMem [32];  // slave side memory
    int       waitLeft;      // slave wait states still to go

    // reference model state
    dataWordT mRegs [4];
    dataWordT mMem [32];
    dataWordT mPc;
    logic     busPending;  // memory access expected on the bus
    logic     expWr;
    dataWordT expAdr;
    dataWordT expDat;
    logic     inCycle;
    logic     lastWasMem;
    int       fetchCount;
    int       cycleGap;    // cycles since last fetch
    int       checkCount = 0;
    int       errCount = 0;
    int       testCount = 0;

    vsaTop u_vsaTop (
        .clock      (clock),
        .rstN       (rstN),
        .instruction(instruction),
        .wbDatI     (wbDatI),
        .wbAck      (wbAck),
        .pc         (pc),
        .wbAdr      (wbAdr),
        .wbDatO     (wbDatO),
        .fetch      (fetch),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe)
    );

    initial begin
        forever #4 clock = ~clock;  // 8 ns period
    end

    always @(negedge clock) instruction <= rom[pc];  // fetch path stable long before IF ends

    // wishbone classic slave with 0 to 3 wait cycles before ack
    always @(negedge clock) begin
        if (!wbCyc) begin
            wbAck    <= 1'b0;
            waitLeft <= $urandom_range(0, 3);
        end else if (!wbAck) begin
            if (waitLeft == 0) begin
                wbAck  <= 1'b1;
                wbDatI <= dataMem[wbAdr];
                if (wbWe)
                    dataMem[wbAdr] = wbDatO;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    function automatic dataWordT randWord();
        return dataWordT'($urandom);
    endfunction

    function automatic regIdxT randReg();
        return regIdxT'($urandom_range(1, 3));  // never r0
    endfunction

    function automatic instrT encodeR(funcT fn, regIdxT s1, regIdxT s2, regIdxT d);
        return {OP_ALU, s1, s2, d, fn};
    endfunction

    // for lw/sw the middle field is the loaded or stored register
    function automatic instrT encodeI(opcodeT op, regIdxT s1, regIdxT d, dataWordT imm);
        return {op, s1, d, imm};
    endfunction

    // executes one instruction on the model and returns the next pc
    function automatic dataWordT refStep(input instrT instr, output logic acc,
                                         output logic wr, output dataWordT adr,
                                         output dataWordT dat);
        dataWordT a;
        dataWordT b;
        dataWordT imm;
        dataWordT res;
        dataWordT nextPc;
        regIdxT   dst;
        logic     writes;
        a      = mRegs[instr[8:7]];
        b      = mRegs[instr[6:5]];
        imm    = instr[4:0];       // raw unsigned
        nextPc = mPc + PC_STEP;
        dst    = instr[6:5];
        writes = 1'b0;
        res    = '0;
        acc    = 1'b0;
        wr     = 1'b0;
        adr    = a + imm;
        dat    = b;
        case (opcodeT'(instr[11:9]))
            OP_LW: begin
                acc    = 1'b1;
                res    = mMem[adr];
                writes = 1'b1;
            end
            OP_SW: begin
                acc       = 1'b1;
                wr        = 1'b1;
                mMem[adr] = b;
            end
            OP_BEQZ: if (a == '0) nextPc = nextPc + dataWordT'(2 * int'(imm[3:0]));
            OP_ALU: begin
                dst    = instr[4:3];
                writes = 1'b1;
                case (funcT'(instr[2:0]))
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOT:  res = ~a;
                    FN_SRL:  res = a >> 1;
                    default: res = dataWordT'($signed(a) >>> 1);
                endcase
            end
            OP_ADDI: begin
                res    = a + imm;
                writes = 1'b1;
            end
            OP_SUBI: begin
                res    = a - imm;
                writes = 1'b1;
            end
            default: ;  // opcodes 6, 7
        endcase
        if (writes && dst != 2'd0)
            mRegs[dst] = res;
        return nextPc;
    endfunction

    task automatic checkWord(string name, dataWordT got, dataWordT exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // pc compared at every fetch and payload at every acked bus cycle
    always @(posedge clock) begin
        if (!rstN) begin
            foreach (mRegs[i]) mRegs[i] = '0;
            mMem       = dataMem;  // model memory follows the slave across runs
            mPc        = '0;
            busPending = 1'b0;
            inCycle    = 1'b0;
            lastWasMem = 1'b0;
            fetchCount = 0;
            cycleGap   = 0;
        end else begin
            if (wbCyc)
                checkBit("wbStb", wbStb, 1'b1);  // strobe rides with every classic cycle
            if (wbCyc && wbAck) begin
                if (busPending) begin
                    checkWord("wbAdr", wbAdr, expAdr);
                    checkBit("wbWe", wbWe, expWr);
                    if (expWr)
                        checkWord("wbDatO", wbDatO, expDat);
                end else begin
                    errCount++;
                    $display("bus cycle acknowledged at %0t with no access expected", $time);
                end
                busPending = 1'b0;
                inCycle    = 1'b0;
            end else if (wbCyc) begin
                inCycle = 1'b1;
            end else if (inCycle) begin
                errCount++;
                $display("wbCyc dropped at %0t before the slave acknowledged", $time);
                inCycle = 1'b0;
            end
            if (fetch) begin
                // bus idle whenever a fetch starts, right after reset too
                checkBit("wbCyc", wbCyc, 1'b0);
                checkBit("wbStb", wbStb, 1'b0);
                if (fetchCount > 0 && !lastWasMem)
                    checkWord("fetch spacing", dataWordT'(cycleGap), 5'd5);
                if (busPending) begin
                    errCount++;
                    $display("memory access before %0t never reached the bus", $time);
                    busPending = 1'b0;
                end
                checkWord("pc", pc, mPc);
                lastWasMem = rom[mPc][11:9] == OP_LW || rom[mPc][11:9] == OP_SW;
                mPc        = refStep(rom[mPc], busPending, expWr, expAdr, expDat);
                fetchCount++;
                cycleGap = 0;
            end
            cycleGap++;
        end
    end

    task automatic holdReset();
        @(negedge clock);
        rstN <= 1'b0;
        foreach (rom[i]) rom[i] = Nop;
    endtask

    // reset for 10 cycles and run until the fetch after the last instruction
    task automatic runTest(string name, int nInstr);
        int errBefore;
        errBefore = errCount;
        repeat (10) @(negedge clock);
        rstN <= 1'b1;
        while (fetchCount <= nInstr) @(negedge clock);
        testCount++;
        if (errCount == errBefore)
            $display("test %s: %0d instructions ok", name, nInstr);
        else
            $display("test %s: %0d errors", name, errCount - errBefore);
    endtask

    task automatic loadStraight();
        for (int i = 0; i < 16; i++) begin
            case ($urandom_range(0, 3))
                0: rom[2*i] = encodeI(OP_ADDI, regIdxT'($urandom), randReg(), randWord());
                1: rom[2*i] = encodeI(OP_SUBI, regIdxT'($urandom), randReg(), randWord());
                2: rom[2*i] = encodeR(funcT'($urandom), randReg(), randReg(), randReg());
                default: rom[2*i] = instrT'({3'd7, 9'($urandom)});  // unused opcode
            endcase
        end
    endtask

    task automatic loadRegOps(int group);
        regIdxT d;
        rom[0] = encodeI(OP_ADDI, 2'd0, 2'd1, randWord() | dataWordT'(group * 16));  // sra sign
        rom[2] = encodeI(OP_ADDI, 2'd0, 2'd2, randWord());
        for (int k = 0; k < 4; k++) begin
            d            = randReg();
            rom[4 + 4*k] = encodeR(funcT'(4 * group + k), 2'd1, 2'd2, d);
            rom[6 + 4*k] = encodeI(OP_SW, 2'd0, d, dataWordT'(k));  // result to word k
        end
    endtask

    task automatic loadMemory();
        dataWordT spot;
        spot    = randWord();
        rom[0]  = encodeI(OP_ADDI, 2'd0, 2'd1, randWord());
        rom[2]  = encodeI(OP_LW, 2'd1, 2'd2, randWord());
        rom[4]  = encodeI(OP_SW, 2'd0, 2'd2, spot);
        rom[6]  = encodeI(OP_ADDI, 2'd2, 2'd3, randWord());
        rom[8]  = encodeI(OP_SW, 2'd1, 2'd3, randWord());
        rom[10] = encodeI(OP_LW, 2'd0, 2'd3, spot);  // reads back the earlier store
        rom[12] = encodeI(OP_SUBI, 2'd3, 2'd2, randWord());
        rom[14] = encodeI(OP_SW, 2'd3, 2'd2, randWord());
        rom[16] = encodeI(OP_LW, 2'd2, 2'd1, randWord());
        rom[18] = encodeI(OP_SW, 2'd1, 2'd1, randWord());
        rom[20] = encodeI(OP_SW, 2'd2, 2'd3, randWord());
    endtask

    task automatic loadBranches();
        for (int i = 1; i < 16; i++) begin
            case ($urandom_range(0, 3))
                0: rom[2*i] = encodeI(OP_BEQZ, 2'd0, 2'd0, dataWordT'($urandom_range(0, 14)));
                1: rom[2*i] = encodeI(OP_BEQZ, randReg(), 2'd0, dataWordT'($urandom_range(0, 14)));
                2: rom[2*i] = encodeI(OP_ADDI, 2'd0, randReg(), 5'd0);  // zero for a taken beqz
                default: rom[2*i] = encodeI(OP_ADDI, randReg(), randReg(), randWord());
            endcase
        end
        rom[0]  = encodeI(OP_BEQZ, 2'd0, 2'd0, 5'd13);  // to 28
        rom[28] = encodeI(OP_BEQZ, 2'd0, 2'd0, 5'd3);   // 36 wraps to 4
    endtask

    task automatic loadZeroWrites();
        rom[0]  = encodeI(OP_ADDI, 2'd0, 2'd1, randWord() | 5'd1);
        rom[2]  = encodeI(OP_ADDI, 2'd1, 2'd0, randWord());
        rom[4]  = encodeR(FN_ADD, 2'd1, 2'd1, 2'd0);
        rom[6]  = encodeI(OP_LW, 2'd1, 2'd0, randWord());
        rom[8]  = encodeI(OP_SUBI, 2'd1, 2'd0, randWord());
        rom[10] = encodeI(OP_SW, 2'd1, 2'd0, randWord());  // store data must be 0
        rom[12] = encodeI(OP_SW, 2'd0, 2'd0, randWord());
    endtask

    initial begin
        void'($urandom(32'h5f40_17bc));
        foreach (dataMem[i]) dataMem[i] = randWord();
        holdReset();
        loadStraight();
        runTest("pc step", 16);
        for (int group = 0; group < 2; group++) begin
            holdReset();
            loadRegOps(group);
            runTest($sformatf("r-format group %0d", group), 10);
        end
        holdReset();
        loadMemory();
        runTest("load store", 11);
        holdReset();
        loadBranches();
        runTest("beqz", 24);
        holdReset();
        loadZeroWrites();
        runTest("r0 writes", 7);
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (LimitCycles) @(posedge clock);
        $display("watchdog: run exceeded %0d cycles without finishing", LimitCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/vsaPkg.sv
rtl/vsaMemIf.sv
rtl/vsaAlu.sv
rtl/vsaRegFile.sv
rtl/vsaDataPort.sv
rtl/vsaSequencer.sv
rtl/vsaTop.sv
tests/vsaTb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator from the file list, run, then judge by the simulation log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vsaTb -f vlog.f -o vsaSim > build.log 2>&1 \
    && ./obj_dir/vsaSim > sim.log 2>&1
grep -q "^Simulation completed successfully$" sim.log 2> /dev/null \
    && echo "run passed" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }
